// File: vslide_types_pkg.sv
package vslide_types_pkg;

    // element width, fixed for this unit
    localparam int ELEM_W = 32;

    // defaults the typedefs below are sized for
    localparam int LANES_DEFAULT = 8;
    localparam int ROWS_DEFAULT  = 8;
    localparam int ELEMS_DEFAULT = LANES_DEFAULT * ROWS_DEFAULT;

    localparam int SHAMT_W = $clog2(ELEMS_DEFAULT) + 2;   // 8 bits for 64 elements
    localparam int ROW_W   = $clog2(ROWS_DEFAULT);

    // one vector element
    typedef logic [ELEM_W-1:0] elem_t;

    // one flag per lane
    typedef logic [LANES_DEFAULT-1:0] lane_mask_t;

    // slide amount in elements, also used as the host element address
    typedef logic [SHAMT_W-1:0] shamt_t;

    // row index inside one lane bank
    typedef logic [ROW_W-1:0] row_t;

endpackage

// File: vslide_ctrl_pkg.sv
package vslide_ctrl_pkg;

    // command to the per-lane offset registers
    typedef enum logic [1:0] {
        OFF_NOP       = 2'd0,
        OFF_ROT_RIGHT = 2'd1,   // lane i takes lane i-1
        OFF_ROT_LEFT  = 2'd2,   // lane i takes lane i+1
        OFF_LOAD      = 2'd3    // parallel load from the adders
    } offset_op_e;

    // what the per-lane adders compute for a parallel load
    typedef enum logic [1:0] {
        ADD_SA_PLUS_LANE              = 2'd0,   // slide up
        ADD_SA_PLUS_NLANES_MINUS_LANE = 2'd1,   // slide down
        ADD_DECREMENT                 = 2'd2    // offset - 1, floor at zero
    } adder_sel_e;

    // slide sequencer
    typedef enum logic [2:0] {
        ST_IDLE  = 3'd0,
        ST_LOAD  = 3'd1,
        ST_COUNT = 3'd2,
        ST_WALK  = 3'd3,
        ST_DONE  = 3'd4
    } seq_state_e;

endpackage

// File: column_offset_register.sv
`timescale 1ns/1ps

module column_offset_register #(
    parameter int VLANE_NUM         = 8,
    parameter int VREG_LOC_PER_LANE = 8
) (
    input  logic                         clk_i,
    input  logic                         rst_i,
    input  vslide_ctrl_pkg::offset_op_e  input_sel_i,
    input  vslide_ctrl_pkg::adder_sel_e  adder_input_sel_i,
    input  logic                         en_comp_i,
    input  logic                         start_decrementor_i,
    input  vslide_types_pkg::shamt_t     shift_amount_i,
    output logic [VLANE_NUM-1:0]         valid_data_o,
    output logic [VLANE_NUM-1:0]         slide_write_data_pattern_o,
    output logic                         enable_write_slide_o
);

    localparam int LANE_W  = $clog2(VLANE_NUM);
    localparam int SA_W    = $bits(vslide_types_pkg::shamt_t);
    localparam int SUM_W   = SA_W + 1;
    localparam int QUOT_W  = SUM_W - LANE_W;
    localparam int OFF_W   = $clog2(VREG_LOC_PER_LANE) + 1;
    localparam int WAIT_W  = SA_W - LANE_W;

    logic [VLANE_NUM-1:0][OFF_W-1:0] offset_q;
    logic [VLANE_NUM-1:0][OFF_W-1:0] offset_d;
    logic [VLANE_NUM-1:0][OFF_W-1:0] load_val;
    logic [VLANE_NUM-1:0]            nonzero;
    logic [VLANE_NUM-1:0]            valid;
    logic [VLANE_NUM-1:0]            pattern_q;
    logic                            en_comp_q;
    logic                            first_row;
    logic [WAIT_W-1:0]               wait_cnt;
    logic                            load_sa;

    //////////////////////////////
    // per-lane adders
    //////////////////////////////
    for (genvar i = 0; i < VLANE_NUM; i++) begin : g_lane
        logic [SUM_W-1:0]  sum;
        logic [QUOT_W-1:0] quot;
        logic [OFF_W-1:0]  next_val;

        always_comb begin
            case (adder_input_sel_i)
                vslide_ctrl_pkg::ADD_SA_PLUS_LANE:
                    sum = SUM_W'(shift_amount_i) + SUM_W'(i);
                vslide_ctrl_pkg::ADD_SA_PLUS_NLANES_MINUS_LANE:
                    sum = SUM_W'(shift_amount_i) + SUM_W'(VLANE_NUM - 1 - i);  // SA + N - 1 - i
                default:
                    sum = '0;
            endcase
            quot = sum[SUM_W-1:LANE_W];   // row offset = sum / lanes

            if (adder_input_sel_i == vslide_ctrl_pkg::ADD_DECREMENT) begin
                next_val = nonzero[i] ? offset_q[i] - 1'b1 : '0;
            end else if (quot > QUOT_W'(VREG_LOC_PER_LANE)) begin
                next_val = OFF_W'(VREG_LOC_PER_LANE);   // past the bank, never valid
            end else begin
                next_val = OFF_W'(quot);
            end
        end

        assign load_val[i] = next_val;
        assign nonzero[i]  = (offset_q[i] != '0);
    end

    // next offsets
    always_comb begin
        case (input_sel_i)
            vslide_ctrl_pkg::OFF_ROT_RIGHT: begin
                for (int i = 1; i < VLANE_NUM; i++) begin
                    offset_d[i] = offset_q[i-1];
                end
                offset_d[0] = offset_q[VLANE_NUM-1];
            end
            vslide_ctrl_pkg::OFF_ROT_LEFT: begin
                for (int i = 0; i < VLANE_NUM - 1; i++) begin
                    offset_d[i] = offset_q[i+1];
                end
                offset_d[VLANE_NUM-1] = offset_q[0];
            end
            vslide_ctrl_pkg::OFF_LOAD: offset_d = load_val;
            default:                   offset_d = offset_q;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            offset_q <= '0;
        end else begin
            offset_q <= offset_d;
        end
    end

    //////////////////////////////
    // valid lanes and first row
    //////////////////////////////
    assign valid     = en_comp_i ? ~nonzero : '0;   // zero offset means source in range
    assign first_row = en_comp_i & ~en_comp_q;      // rising edge of the walk

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            en_comp_q <= 1'b0;
            pattern_q <= '0;
        end else begin
            en_comp_q <= en_comp_i;
            if (first_row) begin
                pattern_q <= valid;   // lanes carrying data in the first row
            end
        end
    end

    assign valid_data_o               = valid;
    assign slide_write_data_pattern_o = pattern_q;

    //////////////////////////////
    // write enable countdown
    //////////////////////////////
    assign load_sa = (input_sel_i == vslide_ctrl_pkg::OFF_LOAD) &&
                     (adder_input_sel_i != vslide_ctrl_pkg::ADD_DECREMENT);

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            wait_cnt <= '0;
        end else if (load_sa) begin
            wait_cnt <= shift_amount_i[SA_W-1:LANE_W];   // SA / lanes
        end else if (start_decrementor_i && wait_cnt != '0) begin
            wait_cnt <= wait_cnt - 1'b1;
        end
    end

    assign enable_write_slide_o = (wait_cnt == '0);

endmodule

// File: slide_sequencer.sv
`timescale 1ns/1ps

module slide_sequencer #(
    parameter int VREG_LOC_PER_LANE = 8
) (
    input  logic                         clk_i,
    input  logic                         rst_i,
    input  logic                         start_i,
    input  logic                         dir_i,
    input  vslide_types_pkg::shamt_t     shamt_i,
    input  logic                         enable_write_i,
    output logic                         busy_o,
    output logic                         done_o,
    output vslide_ctrl_pkg::offset_op_e  offset_op_o,
    output vslide_ctrl_pkg::adder_sel_e  adder_sel_o,
    output logic                         en_comp_o,
    output logic                         start_dec_o,
    output vslide_types_pkg::shamt_t     shamt_o,
    output vslide_types_pkg::row_t       rd_row_o,
    output vslide_types_pkg::row_t       wr_row_o,
    output logic                         row_we_o,
    output logic                         first_row_o
);

    localparam vslide_types_pkg::row_t LAST_ROW = vslide_types_pkg::row_t'(VREG_LOC_PER_LANE - 1);

    vslide_ctrl_pkg::seq_state_e state_q;
    vslide_types_pkg::shamt_t    shamt_q;
    vslide_types_pkg::row_t      walk_q;
    vslide_types_pkg::row_t      wr_row_q;
    logic                        dir_q;

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state_q <= vslide_ctrl_pkg::ST_IDLE;
            shamt_q <= '0;
            dir_q   <= 1'b0;
            walk_q  <= '0;
        end else begin
            case (state_q)
                vslide_ctrl_pkg::ST_IDLE: begin
                    if (start_i) begin
                        shamt_q <= shamt_i;
                        dir_q   <= dir_i;
                        state_q <= vslide_ctrl_pkg::ST_LOAD;
                    end
                end
                vslide_ctrl_pkg::ST_LOAD: state_q <= vslide_ctrl_pkg::ST_COUNT;
                vslide_ctrl_pkg::ST_COUNT: begin
                    if (enable_write_i) begin
                        walk_q  <= '0;
                        state_q <= vslide_ctrl_pkg::ST_WALK;
                    end
                end
                vslide_ctrl_pkg::ST_WALK: begin
                    walk_q <= walk_q + 1'b1;
                    if (walk_q == LAST_ROW) begin
                        state_q <= vslide_ctrl_pkg::ST_DONE;
                    end
                end
                default: state_q <= vslide_ctrl_pkg::ST_IDLE;   // DONE
            endcase
        end
    end

    // write row trails the read row by the rotator stage
    always_ff @(posedge clk_i) begin
        wr_row_q <= rd_row_o;
    end

    // up walks rows upward, down walks from the top row
    assign rd_row_o = dir_q ? walk_q : LAST_ROW - walk_q;
    assign wr_row_o = wr_row_q;

    always_comb begin
        offset_op_o = vslide_ctrl_pkg::OFF_NOP;
        adder_sel_o = vslide_ctrl_pkg::ADD_DECREMENT;
        if (state_q == vslide_ctrl_pkg::ST_LOAD) begin
            offset_op_o = vslide_ctrl_pkg::OFF_LOAD;
            adder_sel_o = dir_q ? vslide_ctrl_pkg::ADD_SA_PLUS_LANE
                                : vslide_ctrl_pkg::ADD_SA_PLUS_NLANES_MINUS_LANE;
        end else if (state_q == vslide_ctrl_pkg::ST_WALK) begin
            offset_op_o = vslide_ctrl_pkg::OFF_LOAD;   // step offsets toward zero
        end
    end

    assign busy_o      = (state_q != vslide_ctrl_pkg::ST_IDLE);
    assign done_o      = (state_q == vslide_ctrl_pkg::ST_DONE);
    assign en_comp_o   = (state_q == vslide_ctrl_pkg::ST_WALK);
    assign start_dec_o = (state_q == vslide_ctrl_pkg::ST_COUNT);
    assign row_we_o    = (state_q == vslide_ctrl_pkg::ST_WALK);
    assign first_row_o = (state_q == vslide_ctrl_pkg::ST_WALK) && (walk_q == '0);
    assign shamt_o     = shamt_q;

endmodule

// File: vlane_slice.sv
`timescale 1ns/1ps

module vlane_slice #(
    parameter int VREG_LOC_PER_LANE = 8
) (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      host_we_i,
    input  vslide_types_pkg::row_t    host_row_i,
    input  vslide_types_pkg::elem_t   host_wdata_i,
    output vslide_types_pkg::elem_t   host_rdata_o,
    input  vslide_types_pkg::row_t    rd_row_i,
    output vslide_types_pkg::elem_t   rd_data_o,
    input  logic                      wr_en_i,
    input  vslide_types_pkg::row_t    wr_row_i,
    input  vslide_types_pkg::elem_t   wr_data_i
);

    vslide_types_pkg::elem_t src_bank [VREG_LOC_PER_LANE];
    vslide_types_pkg::elem_t dst_bank [VREG_LOC_PER_LANE];

    // source column, host side only
    always_ff @(posedge clk_i) begin
        if (host_we_i) begin
            src_bank[host_row_i] <= host_wdata_i;
        end
    end

    // destination column, cleared so unslid reads give zero
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            for (int r = 0; r < VREG_LOC_PER_LANE; r++) begin
                dst_bank[r] <= '0;
            end
        end else if (wr_en_i) begin
            dst_bank[wr_row_i] <= wr_data_i;
        end
    end

    assign rd_data_o    = src_bank[rd_row_i];
    assign host_rdata_o = dst_bank[host_row_i];

endmodule

// File: slide_rotator.sv
`timescale 1ns/1ps

module slide_rotator #(
    parameter int VLANE_NUM = 8
) (
    input  logic                                     clk_i,
    input  logic                                     rst_i,
    input  vslide_types_pkg::elem_t [VLANE_NUM-1:0]  rd_data_i,
    input  logic [VLANE_NUM-1:0]                     valid_i,
    input  logic [VLANE_NUM-1:0]                     pattern_i,
    input  logic                                     first_row_i,
    input  logic                                     row_we_i,
    input  logic                                     dir_i,
    input  vslide_types_pkg::shamt_t                 shamt_i,
    output vslide_types_pkg::elem_t [VLANE_NUM-1:0]  wr_data_o,
    output logic [VLANE_NUM-1:0]                     wr_en_o
);

    localparam int LANE_W = $clog2(VLANE_NUM);

    vslide_types_pkg::elem_t [VLANE_NUM-1:0] data_q;
    logic [VLANE_NUM-1:0]                    valid_q;
    logic                                    we_q;
    logic                                    first_q;
    logic [LANE_W-1:0]                       rot;

    assign rot = shamt_i[LANE_W-1:0];   // SA mod lanes

    // row register, invalid lanes forced to zero
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < VLANE_NUM; i++) begin
            data_q[i] <= valid_i[i] ? rd_data_i[i] : '0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            valid_q <= '0;
            we_q    <= 1'b0;
            first_q <= 1'b0;
        end else begin
            valid_q <= valid_i;
            we_q    <= row_we_i;
            first_q <= first_row_i;
        end
    end

    // dest lane j pulls from source lane j+rot (down) or j-rot (up)
    always_comb begin
        logic [LANE_W-1:0] src;
        for (int j = 0; j < VLANE_NUM; j++) begin
            src = dir_i ? LANE_W'(j) - rot : LANE_W'(j) + rot;
            wr_data_o[j] = data_q[src];
            // first row writes data lanes plus the zero-filled ones
            wr_en_o[j] = we_q & (~first_q | pattern_i[src] | ~valid_q[src]);
        end
    end

endmodule

// File: vslide_top.sv
`timescale 1ns/1ps

module vslide_top #(
    parameter int VLANE_NUM         = 8,
    parameter int VREG_LOC_PER_LANE = 8
) (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      elem_we_i,
    input  vslide_types_pkg::shamt_t  elem_addr_i,
    input  vslide_types_pkg::elem_t   elem_wdata_i,
    output vslide_types_pkg::elem_t   elem_rdata_o,
    input  logic                      start_i,
    input  logic                      dir_i,
    input  vslide_types_pkg::shamt_t  shamt_i,
    output logic                      busy_o,
    output logic                      done_o
);

    localparam int LANE_W = $clog2(VLANE_NUM);
    localparam int ROW_W  = $bits(vslide_types_pkg::row_t);
    localparam int SUM_W  = $bits(vslide_types_pkg::shamt_t) + 1;

    vslide_ctrl_pkg::offset_op_e offset_op;
    vslide_ctrl_pkg::adder_sel_e adder_sel;
    logic                        en_comp, start_dec, enable_write;
    logic                        row_we, first_row, dir_q;
    vslide_types_pkg::shamt_t    slide_shamt;
    vslide_types_pkg::row_t      rd_row, wr_row, host_row;
    logic [LANE_W-1:0]           host_lane;
    logic [VLANE_NUM-1:0]        valid_data, write_pattern, lane_we;

    vslide_types_pkg::elem_t [VLANE_NUM-1:0] rd_data, wr_data, host_rdata;

    assign host_lane = elem_addr_i[LANE_W-1:0];
    assign host_row  = elem_addr_i[LANE_W +: ROW_W];

    // direction held for the rotator and lane address math
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            dir_q <= 1'b0;
        end else if (start_i && !busy_o) begin
            dir_q <= dir_i;
        end
    end

    slide_sequencer #(.VREG_LOC_PER_LANE(VREG_LOC_PER_LANE)) u_slide_sequencer (
        .clk_i(clk_i), .rst_i(rst_i), .start_i(start_i), .dir_i(dir_i), .shamt_i(shamt_i),
        .enable_write_i(enable_write), .busy_o(busy_o), .done_o(done_o),
        .offset_op_o(offset_op), .adder_sel_o(adder_sel), .en_comp_o(en_comp),
        .start_dec_o(start_dec), .shamt_o(slide_shamt), .rd_row_o(rd_row),
        .wr_row_o(wr_row), .row_we_o(row_we), .first_row_o(first_row)
    );

    column_offset_register #(
        .VLANE_NUM(VLANE_NUM), .VREG_LOC_PER_LANE(VREG_LOC_PER_LANE)
    ) u_column_offset_register (
        .clk_i(clk_i), .rst_i(rst_i), .input_sel_i(offset_op),
        .adder_input_sel_i(adder_sel), .en_comp_i(en_comp), .start_decrementor_i(start_dec),
        .shift_amount_i(slide_shamt), .valid_data_o(valid_data),
        .slide_write_data_pattern_o(write_pattern), .enable_write_slide_o(enable_write)
    );

    for (genvar i = 0; i < VLANE_NUM; i++) begin : g_lane
        logic [SUM_W-1:0]       sum;
        vslide_types_pkg::row_t lane_off, lane_rd_row;

        // same offset the column register walks for this lane
        assign sum         = SUM_W'(slide_shamt) + SUM_W'(dir_q ? i : VLANE_NUM - 1 - i);
        assign lane_off    = sum[LANE_W +: ROW_W];
        assign lane_rd_row = dir_q ? rd_row - lane_off : rd_row + lane_off;

        vlane_slice #(.VREG_LOC_PER_LANE(VREG_LOC_PER_LANE)) u_vlane_slice (
            .clk_i(clk_i), .rst_i(rst_i),
            .host_we_i(elem_we_i && host_lane == LANE_W'(i)), .host_row_i(host_row),
            .host_wdata_i(elem_wdata_i), .host_rdata_o(host_rdata[i]),
            .rd_row_i(lane_rd_row), .rd_data_o(rd_data[i]),
            .wr_en_i(lane_we[i]), .wr_row_i(wr_row), .wr_data_i(wr_data[i])
        );
    end

    slide_rotator #(.VLANE_NUM(VLANE_NUM)) u_slide_rotator (
        .clk_i(clk_i), .rst_i(rst_i), .rd_data_i(rd_data), .valid_i(valid_data),
        .pattern_i(write_pattern), .first_row_i(first_row), .row_we_i(row_we),
        .dir_i(dir_q), .shamt_i(slide_shamt), .wr_data_o(wr_data), .wr_en_o(lane_we)
    );

    assign elem_rdata_o = host_rdata[host_lane];

endmodule

// File: vslide_tb.sv
`timescale 1ns/1ps

module vslide_tb;

    localparam int NELEM    = 64;
    localparam int RAND_N   = 10;
    localparam int CASE_CYC = NELEM * 2 + NELEM + 40;   // budget per case

    logic                      clk_i = 1'b0;
    logic                      rst_i;
    logic                      elem_we_i;
    vslide_types_pkg::shamt_t  elem_addr_i;
    vslide_types_pkg::elem_t   elem_wdata_i;
    vslide_types_pkg::elem_t   elem_rdata_o;
    logic                      start_i;
    logic                      dir_i;
    vslide_types_pkg::shamt_t  shamt_i;
    logic                      busy_o;
    logic                      done_o;

    // five down and five up cases beyond the golden file
    int rand_dir [RAND_N] = '{0, 0, 0, 0, 0, 1, 1, 1, 1, 1};
    int rand_sa  [RAND_N] = '{0, 8, 13, 63, 64, 0, 3, 8, 63, 255};

    logic [31:0] src_mem [NELEM];
    logic [31:0] exp_mem [NELEM];
    logic [31:0] gold_src [$];
    logic [31:0] gold_exp [$];
    int          gold_dir [$];
    int          gold_sa  [$];

    int          seed = 32'hcb9d;
    int          errors = 0;
    int          starts = 0;
    int          done_cnt = 0;
    int unsigned cycle_cnt = 0;
    int unsigned cycle_limit = 0;

    always #2 clk_i = ~clk_i;

    vslide_top #(.VLANE_NUM(8), .VREG_LOC_PER_LANE(8)) u_vslide_top (
        .clk_i(clk_i), .rst_i(rst_i), .elem_we_i(elem_we_i), .elem_addr_i(elem_addr_i),
        .elem_wdata_i(elem_wdata_i), .elem_rdata_o(elem_rdata_o), .start_i(start_i),
        .dir_i(dir_i), .shamt_i(shamt_i), .busy_o(busy_o), .done_o(done_o)
    );

    always @(negedge clk_i) begin
        if (done_o) begin
            done_cnt <= done_cnt + 1;   // one count per pulse
        end
    end

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
            $display("timeout after %0d cycles, the slide never finished", cycle_cnt);
            $display("TEST FAIL");
            $finish;
        end
    end

    //////////////////////////////
    // helpers
    //////////////////////////////
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic load_golden();
        int          fd;
        int          rc;
        int          d;
        int          sa;
        logic [31:0] w;
        string       line;
        fd = $fopen("vslide_golden.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("cannot open vslide_golden.txt, golden cases skipped");
        end else begin
            while ($fgets(line, fd) != 0) begin
                // comments and blank lines fail the header scan
                if ($sscanf(line, "%h %h", d, sa) == 2) begin
                    gold_dir.push_back(d);
                    gold_sa.push_back(sa);
                    for (int k = 0; k < 2 * NELEM; k++) begin
                        rc = $fscanf(fd, "%h", w);
                        if (rc != 1) begin
                            errors++;
                            $display("golden file ends inside case %0d", gold_dir.size() - 1);
                        end
                        if (k < NELEM) begin
                            gold_src.push_back(w);
                        end else begin
                            gold_exp.push_back(w);
                        end
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic randomize_source();
        for (int e = 0; e < NELEM; e++) begin
            src_mem[e] = $random(seed);
        end
    endtask

    // slide rule applied to the source image
    task automatic fill_expected(input int d, input int sa);
        for (int e = 0; e < NELEM; e++) begin
            if (d == 0) begin
                exp_mem[e] = (e + sa < NELEM) ? src_mem[e + sa] : '0;
            end else begin
                exp_mem[e] = (e >= sa) ? src_mem[e - sa] : '0;
            end
        end
    endtask

    task automatic write_source();
        for (int e = 0; e < NELEM; e++) begin
            @(posedge clk_i);
            elem_we_i    <= 1'b1;
            elem_addr_i  <= 8'(e);
            elem_wdata_i <= src_mem[e];
        end
        @(posedge clk_i);
        elem_we_i <= 1'b0;
    endtask

    task automatic start_slide(input int d, input int sa);
        @(posedge clk_i);
        start_i <= 1'b1;
        dir_i   <= (d != 0);
        shamt_i <= 8'(sa);
        @(posedge clk_i);
        start_i <= 1'b0;
    endtask

    task automatic wait_done();
        do begin
            @(negedge clk_i);
        end while (!done_o);
    endtask

    task automatic read_and_compare(input string tag);
        for (int e = 0; e < NELEM; e++) begin
            @(posedge clk_i);
            elem_addr_i <= 8'(e);
            @(negedge clk_i);
            check_value($sformatf("elem_rdata_o[%0d] (%s)", e, tag), elem_rdata_o, exp_mem[e]);
        end
    endtask

    task automatic run_case(input int d, input int sa, input string tag);
        write_source();
        start_slide(d, sa);
        starts++;
        wait_done();
        read_and_compare(tag);
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////
    initial begin
        rst_i        = 1'b0;
        elem_we_i    = 1'b0;
        elem_addr_i  = '0;
        elem_wdata_i = '0;
        start_i      = 1'b0;
        dir_i        = 1'b0;
        shamt_i      = '0;

        load_golden();
        cycle_limit = (gold_dir.size() + RAND_N + 2) * CASE_CYC;

        repeat (8) @(posedge clk_i);
        rst_i <= 1'b1;
        @(negedge clk_i);
        check_value("busy_o", 32'(busy_o), 32'd0);
        check_value("done_o", 32'(done_o), 32'd0);

        // source loaded but never slid
        randomize_source();
        write_source();
        for (int e = 0; e < NELEM; e++) begin
            exp_mem[e] = '0;
        end
        read_and_compare("before any slide");

        for (int c = 0; c < gold_dir.size(); c++) begin
            for (int e = 0; e < NELEM; e++) begin
                src_mem[e] = gold_src[c * NELEM + e];
                exp_mem[e] = gold_exp[c * NELEM + e];
            end
            run_case(gold_dir[c], gold_sa[c], $sformatf("golden case %0d", c));
        end

        for (int c = 0; c < RAND_N; c++) begin
            randomize_source();
            fill_expected(rand_dir[c], rand_sa[c]);
            run_case(rand_dir[c], rand_sa[c],
                     $sformatf("dir %0d sa %0d", rand_dir[c], rand_sa[c]));
        end

        // second start lands while busy and must be dropped
        randomize_source();
        fill_expected(0, 5);
        write_source();
        start_slide(0, 5);
        starts++;
        @(negedge clk_i);
        check_value("busy_o", 32'(busy_o), 32'd1);
        start_slide(1, 20);
        wait_done();
        read_and_compare("start while busy");
        repeat (40) @(posedge clk_i);   // room for a stray second done

        check_value("done_o count", 32'(done_cnt), 32'(starts));
        $display("errors %0d, done pulses %0d, starts %0d", errors, done_cnt, starts);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: vslide_golden.txt
# case header: direction (0 down, 1 up) and shift amount, both hex
# then 64 source words and 64 expected words, hex, 8 per line, element 0 first
0 03
c0de0000 c0de0001 c0de0002 c0de0003 c0de0004 c0de0005 c0de0006 c0de0007
c0de0008 c0de0009 c0de000a c0de000b c0de000c c0de000d c0de000e c0de000f
c0de0010 c0de0011 c0de0012 c0de0013 c0de0014 c0de0015 c0de0016 c0de0017
c0de0018 c0de0019 c0de001a c0de001b c0de001c c0de001d c0de001e c0de001f
c0de0020 c0de0021 c0de0022 c0de0023 c0de0024 c0de0025 c0de0026 c0de0027
c0de0028 c0de0029 c0de002a c0de002b c0de002c c0de002d c0de002e c0de002f
c0de0030 c0de0031 c0de0032 c0de0033 c0de0034 c0de0035 c0de0036 c0de0037
c0de0038 c0de0039 c0de003a c0de003b c0de003c c0de003d c0de003e c0de003f
c0de0003 c0de0004 c0de0005 c0de0006 c0de0007 c0de0008 c0de0009 c0de000a
c0de000b c0de000c c0de000d c0de000e c0de000f c0de0010 c0de0011 c0de0012
c0de0013 c0de0014 c0de0015 c0de0016 c0de0017 c0de0018 c0de0019 c0de001a
c0de001b c0de001c c0de001d c0de001e c0de001f c0de0020 c0de0021 c0de0022
c0de0023 c0de0024 c0de0025 c0de0026 c0de0027 c0de0028 c0de0029 c0de002a
c0de002b c0de002c c0de002d c0de002e c0de002f c0de0030 c0de0031 c0de0032
c0de0033 c0de0034 c0de0035 c0de0036 c0de0037 c0de0038 c0de0039 c0de003a
c0de003b c0de003c c0de003d c0de003e c0de003f 00000000 00000000 00000000

1 0d
beef0000 beef0001 beef0002 beef0003 beef0004 beef0005 beef0006 beef0007
beef0008 beef0009 beef000a beef000b beef000c beef000d beef000e beef000f
beef0010 beef0011 beef0012 beef0013 beef0014 beef0015 beef0016 beef0017
beef0018 beef0019 beef001a beef001b beef001c beef001d beef001e beef001f
beef0020 beef0021 beef0022 beef0023 beef0024 beef0025 beef0026 beef0027
beef0028 beef0029 beef002a beef002b beef002c beef002d beef002e beef002f
beef0030 beef0031 beef0032 beef0033 beef0034 beef0035 beef0036 beef0037
beef0038 beef0039 beef003a beef003b beef003c beef003d beef003e beef003f
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 beef0000 beef0001 beef0002
beef0003 beef0004 beef0005 beef0006 beef0007 beef0008 beef0009 beef000a
beef000b beef000c beef000d beef000e beef000f beef0010 beef0011 beef0012
beef0013 beef0014 beef0015 beef0016 beef0017 beef0018 beef0019 beef001a
beef001b beef001c beef001d beef001e beef001f beef0020 beef0021 beef0022
beef0023 beef0024 beef0025 beef0026 beef0027 beef0028 beef0029 beef002a
beef002b beef002c beef002d beef002e beef002f beef0030 beef0031 beef0032

// File: src.f
vslide_types_pkg.sv
vslide_ctrl_pkg.sv
column_offset_register.sv
slide_sequencer.sv
vlane_slice.sv
slide_rotator.sv
vslide_top.sv
vslide_tb.sv

// File: Makefile
TOP = vslide_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module vslide_top -f src.f

sim:
	verilator --binary --timing -j 0 --top-module $(TOP) -f src.f
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir
